//--- acc_writer.sv
/*
 * accumulation buffer write port of one readout channel
 * address locks at the last entry, sign of x gives the state measurement
 */
`timescale 1ns/10ps
`default_nettype none

module acc_writer import dsp_pkg::*; (
	input  logic        dspif,
	input  logic        rst_n,
	input  logic        acc_reset,
	input  acc_sample_t sample,
	output acc_wr_t     wr,
	output meas_t       meas
);

	logic                    we_q;
	acc_addr_t               addr_q;
	logic [2*ACC_AXIS_W-1:0] data_q;
	logic                    meas_valid_q;
	logic                    meas_state_q;

	// last entry reached, stop advancing
	logic addr_lock;

	assign addr_lock = &addr_q;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			we_q <= 1'b0;
			addr_q <= '0;
			meas_valid_q <= 1'b0;
		end else begin
			we_q <= sample.valid;
			meas_valid_q <= we_q;
			// host clear wins over the post-write advance
			if (acc_reset) begin
				addr_q <= '0;
			end else if (we_q && !addr_lock) begin
				addr_q <= addr_q + 1'b1;
			end
		end
	end

	// payload path
	always_ff @(posedge dspif) begin
		if (sample.valid) begin
			data_q <= {sample.x, sample.y};
		end
		// threshold on the real axis
		meas_state_q <= data_q[2*ACC_AXIS_W-1];
	end

	assign wr = '{we: we_q, addr: addr_q, data: data_q};
	assign meas = '{valid: meas_valid_q, state: meas_state_q};

endmodule

`default_nettype wire

//--- dsp_checker.sv
/*
 * concurrent assertions on the dsp_top ports, attached by bind
 */
`timescale 1ns/10ps
`default_nettype none

module dsp_checker import dsp_pkg::*; (
	input logic    dspif,
	input logic    rst_n,
	input logic    run_req,
	input logic    run_ack,
	input logic    proc_reset,
	input logic    acc_reset,
	input acc_wr_t acc_wr [N_CHAN]
);

	// failures seen so far, read by the testbench at the end of the run
	int fail_count = 0;

	// cores stay in reset while the run is acknowledged
	ack_in_reset: assert property (@(posedge dspif) disable iff (!rst_n)
		run_ack |-> proc_reset)
		else begin
			fail_count++;
			$error("run_ack high while cores are out of reset");
		end

	// four-phase handshake, ack held until the request drops
	ack_held: assert property (@(posedge dspif) disable iff (!rst_n)
		(run_ack && run_req) |=> run_ack)
		else begin
			fail_count++;
			$error("run_ack dropped while run_req still high");
		end

	// locked address only leaves the last entry through a host clear
	for (genvar i = 0; i < N_CHAN; i++) begin : gen_lock
		addr_lock_held: assert property (@(posedge dspif) disable iff (!rst_n)
			(acc_wr[i].addr == '1 && !acc_reset) |=> (acc_wr[i].addr != '0))
			else begin
				fail_count++;
				$error("buffer address wrapped to zero without acc_reset");
			end
	end

endmodule

`default_nettype wire

//--- dsp_pkg.sv
/*
 * shared widths and counts of the shot sequencer and accumulation writers,
 * vector typedefs, run state enum, sample / buffer write / measurement structs
 */
`default_nettype none

package dsp_pkg;

	// core and readout channel counts
	localparam int N_CORE = 2;
	localparam int N_CHAN = 2;

	// shot count width
	localparam int SHOT_W = 32;

	// one accumulated axis, signed
	localparam int ACC_AXIS_W = 32;

	// small buffer so the lock at the last address is reachable
	localparam int ACC_ADDR_W = 4;

	typedef logic [SHOT_W-1:0] shot_cnt_t;
	typedef logic signed [ACC_AXIS_W-1:0] acc_axis_t;
	typedef logic [ACC_ADDR_W-1:0] acc_addr_t;
	typedef logic [N_CORE-1:0] core_vec_t;

	// run sequencing, gray-ish encoding around the shot loop
	typedef enum logic [2:0] {
		IDLE     = 3'b000,
		START    = 3'b001,
		PROCRUN  = 3'b011,
		ELEMBUSY = 3'b010,
		MORESHOT = 3'b110,
		SHOTADD  = 3'b111,
		DONE     = 3'b101
	} run_state_t;

	// one accumulated demod result
	// valid pulses for a single cycle
	typedef struct packed {
		logic      valid;
		acc_axis_t x;
		acc_axis_t y;
	} acc_sample_t;

	// one accumulation buffer write
	// data holds x in the upper half, y in the lower
	typedef struct packed {
		logic                    we;
		acc_addr_t               addr;
		logic [2*ACC_AXIS_W-1:0] data;
	} acc_wr_t;

	// one state measurement for mid-circuit feedback
	// state is the sign of the real axis
	typedef struct packed {
		logic valid;
		logic state;
	} meas_t;

endpackage

`default_nettype wire

//--- dsp_top.sv
/*
 * top level: shot sequencer FSM and counter, one buffer writer per channel
 */
`timescale 1ns/10ps
`default_nettype none

module dsp_top import dsp_pkg::*; (
	input  logic        dspif,
	input  logic        rst_n,
	input  logic        run_req,
	input  shot_cnt_t   nshot,
	input  logic        acc_reset,
	input  core_vec_t   proc_done,
	input  core_vec_t   elem_idle,
	input  acc_sample_t acc_in [N_CHAN],
	output logic        run_ack,
	output logic        proc_reset,
	output shot_cnt_t   last_shot,
	output acc_wr_t     acc_wr [N_CHAN],
	output meas_t       meas [N_CHAN]
);

	// fsm to counter
	logic count_clear;
	logic count_advance;
	logic more_shots;

	shot_fsm shot_fsm_i (
		.dspif         (dspif),
		.rst_n         (rst_n),
		.run_req       (run_req),
		.proc_done     (proc_done),
		.elem_idle     (elem_idle),
		.more_shots    (more_shots),
		.proc_reset    (proc_reset),
		.run_ack       (run_ack),
		.count_clear   (count_clear),
		.count_advance (count_advance)
	);

	shot_counter shot_counter_i (
		.dspif         (dspif),
		.rst_n         (rst_n),
		.nshot         (nshot),
		.count_clear   (count_clear),
		.count_advance (count_advance),
		.more_shots    (more_shots),
		.last_shot     (last_shot)
	);

	// one writer per readout channel, shared address clear
	for (genvar i = 0; i < N_CHAN; i++) begin : gen_chan
		acc_writer acc_writer_i (
			.dspif     (dspif),
			.rst_n     (rst_n),
			.acc_reset (acc_reset),
			.sample    (acc_in[i]),
			.wr        (acc_wr[i]),
			.meas      (meas[i])
		);
	end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# compile and run the dsp testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f --top-module tb_dsp -Mdir obj_dir -o sim_tb_dsp
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_tb_dsp +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Verification passed" "$LOG"; then
	exit 0
fi
echo "pass message not found in $LOG"
exit 1

//--- shot_counter.sv
/*
 * shot counter, latches requested count and tracks completed shots
 */
`timescale 1ns/10ps
`default_nettype none

module shot_counter import dsp_pkg::*; (
	input  logic      dspif,
	input  logic      rst_n,
	input  shot_cnt_t nshot,
	input  logic      count_clear,
	input  logic      count_advance,
	output logic      more_shots,
	output shot_cnt_t last_shot
);

	shot_cnt_t nshot_q;
	shot_cnt_t count;
	shot_cnt_t count_next;

	assign count_next = count + 1'b1;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			nshot_q <= '0;
			count <= '0;
			last_shot <= '0;
			more_shots <= 1'b0;
		end else begin
			// request latched while idle, frozen once a run starts
			if (count_clear) begin
				nshot_q <= nshot;
				count <= '0;
			end else if (count_advance) begin
				last_shot <= count;
				count <= count_next;
			end
			// zero shots requested means run until reset
			more_shots <= (count_next != nshot_q) || (nshot_q == '0);
		end
	end

endmodule

`default_nettype wire

//--- shot_fsm.sv
/*
 * run state machine of the shot sequencer
 * drives core reset, host req/ack handshake and the shot counter controls
 */
`timescale 1ns/10ps
`default_nettype none

module shot_fsm import dsp_pkg::*; (
	input  logic      dspif,
	input  logic      rst_n,
	input  logic      run_req,
	input  core_vec_t proc_done,
	input  core_vec_t elem_idle,
	input  logic      more_shots,
	output logic      proc_reset,
	output logic      run_ack,
	output logic      count_clear,
	output logic      count_advance
);

	run_state_t state_q;
	run_state_t state_d;

	// registered reductions over all cores
	logic all_done_q;
	logic all_idle_q;

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			all_done_q <= 1'b0;
			all_idle_q <= 1'b0;
		end else begin
			all_done_q <= &proc_done;
			all_idle_q <= &elem_idle;
		end
	end

	always_comb begin
		state_d = IDLE;
		case (state_q)
			IDLE:
				state_d = run_req ? START : IDLE;
			// cores leave reset one cycle after entering here
			START:
				state_d = PROCRUN;
			PROCRUN:
				state_d = all_done_q ? ELEMBUSY : PROCRUN;
			// cores back in reset, wait for elements to drain
			ELEMBUSY:
				state_d = all_idle_q ? MORESHOT : ELEMBUSY;
			MORESHOT:
				state_d = SHOTADD;
			// more_shots still reflects the count before this advance
			SHOTADD:
				state_d = more_shots ? START : DONE;
			// hold the ack until the host drops its request
			DONE:
				state_d = run_req ? DONE : IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// registered outputs
	// core reset low only while a shot runs
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			proc_reset <= 1'b1;
			run_ack <= 1'b0;
		end else begin
			proc_reset <= !(state_q == START || state_q == PROCRUN);
			run_ack <= (state_d == DONE);
		end
	end

	// counter controls
	assign count_clear = (state_q == IDLE);
	assign count_advance = (state_q == SHOTADD);

endmodule

`default_nettype wire

//--- sources.f
dsp_pkg.sv
shot_fsm.sv
shot_counter.sv
acc_writer.sv
dsp_top.sv
dsp_checker.sv
tb_dsp.sv

//--- tb_dsp.sv
/*
 * testbench of dsp_top with clock, reset, core and element model,
 * run and sample stimulus, reference functions and output comparison
 */
`timescale 1ns/10ps
`default_nettype none

module tb_dsp import dsp_pkg::*; ();

	localparam logic [31:0] SEED = 32'hab02be9e;

	logic        dspif;
	logic        rst_n;
	logic        run_req;
	shot_cnt_t   nshot;
	logic        acc_reset;
	core_vec_t   proc_done;
	core_vec_t   elem_idle;
	acc_sample_t acc_in [N_CHAN];
	logic        run_ack;
	logic        proc_reset;
	shot_cnt_t   last_shot;
	acc_wr_t     acc_wr [N_CHAN];
	meas_t       meas [N_CHAN];

	int errors = 0;
	int checks = 0;
	int tests = 0;
	int test_base = 0;
	int window_cnt = 0;
	logic proc_reset_prev = 1'b1;
	logic [31:0] core_rng = SEED;
	logic [31:0] data_rng = SEED ^ 32'h5a5a5a5a;
	int unsigned done_cnt [N_CORE];
	int unsigned idle_cnt [N_CORE];
	acc_wr_t exp_wr_q [N_CHAN][$];
	logic exp_meas_q [N_CHAN][$];
	acc_addr_t exp_addr [N_CHAN];

	dsp_top dsp_top_i (.*);

	bind dsp_top dsp_checker dsp_checker_i (
		.dspif      (dspif),
		.rst_n      (rst_n),
		.run_req    (run_req),
		.run_ack    (run_ack),
		.proc_reset (proc_reset),
		.acc_reset  (acc_reset),
		.acc_wr     (acc_wr)
	);

	function automatic logic [31:0] lcg(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// reference rules
	function automatic int exp_windows(input shot_cnt_t n);
		return int'(n);
	endfunction

	function automatic shot_cnt_t exp_last_shot(input shot_cnt_t n);
		return n - shot_cnt_t'(1);
	endfunction

	function automatic acc_addr_t next_addr(input acc_addr_t a);
		return (a == '1) ? a : a + acc_addr_t'(1);
	endfunction

	function automatic logic exp_state(input acc_axis_t x);
		return (x < 0);
	endfunction

	function automatic int unsigned core_delay();
		core_rng = lcg(core_rng);
		return 2 + int'(core_rng[19:16]) % 6;
	endfunction

	function automatic int pending();
		int n;
		n = 0;
		for (int c = 0; c < N_CHAN; c++) begin
			n += exp_wr_q[c].size() + exp_meas_q[c].size();
		end
		return n;
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("FAILED %s got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	initial begin
		dspif = 1'b0;
		forever #50 dspif = ~dspif;
	end

	// core model raises done some cycles after release and idle some cycles after reset
	always @(posedge dspif) begin
		for (int c = 0; c < N_CORE; c++) begin
			if (proc_reset) begin
				proc_done[c] <= 1'b0;
				done_cnt[c] <= core_delay();
				if (idle_cnt[c] != 0)
					idle_cnt[c] <= idle_cnt[c] - 1;
				else
					elem_idle[c] <= 1'b1;
			end else begin
				elem_idle[c] <= 1'b0;
				idle_cnt[c] <= core_delay();
				if (done_cnt[c] != 0)
					done_cnt[c] <= done_cnt[c] - 1;
				else
					proc_done[c] <= 1'b1;
			end
		end
	end

	// one shot window per falling core reset
	always @(posedge dspif) begin
		if (proc_reset_prev && !proc_reset)
			window_cnt++;
		proc_reset_prev = proc_reset;
	end

	// compare buffer writes and measurements against expected queues
	always @(negedge dspif) begin : compare
		acc_wr_t exp_wr;
		logic exp_bit;
		for (int c = 0; c < N_CHAN; c++) begin
			if (acc_wr[c].we === 1'b1) begin
				if (exp_wr_q[c].size() == 0) begin
					$display("buffer write on channel %0d with no sample pending", c);
					errors++;
				end else begin
					exp_wr = exp_wr_q[c].pop_front();
					check_value($sformatf("acc_wr[%0d].addr", c), acc_wr[c].addr, exp_wr.addr);
					check_value($sformatf("acc_wr[%0d].data", c), acc_wr[c].data, exp_wr.data);
				end
			end
			if (meas[c].valid === 1'b1) begin
				if (exp_meas_q[c].size() == 0) begin
					$display("measurement on channel %0d with no sample pending", c);
					errors++;
				end else begin
					exp_bit = exp_meas_q[c].pop_front();
					check_value($sformatf("meas[%0d].state", c), meas[c].state, exp_bit);
				end
			end
		end
	end

	task automatic wait_ack(input logic level, input int limit, output bit ok);
		ok = 1'b0;
		for (int n = 0; n < limit && !ok; n++) begin
			@(negedge dspif);
			ok = (run_ack === level);
		end
		if (!ok) begin
			$display("timeout waiting for run_ack to go to %0b", level);
			errors++;
		end
	endtask

	task automatic wait_drain(input int limit);
		bit done;
		done = 1'b0;
		for (int n = 0; n < limit && !done; n++) begin
			@(negedge dspif);
			done = (pending() == 0);
		end
		if (!done) begin
			$display("timeout with %0d buffer writes or measurements missing", pending());
			errors++;
		end
	endtask

	task automatic check_reset_state();
		check_value("run_ack", run_ack, 0);
		check_value("proc_reset", proc_reset, 1);
		check_value("last_shot", last_shot, 0);
		for (int c = 0; c < N_CHAN; c++) begin
			check_value($sformatf("acc_wr[%0d].we", c), acc_wr[c].we, 0);
			check_value($sformatf("acc_wr[%0d].addr", c), acc_wr[c].addr, 0);
			check_value($sformatf("meas[%0d].valid", c), meas[c].valid, 0);
		end
	endtask

	// one complete four-phase run
	task automatic run_shots(input shot_cnt_t n);
		bit ok;
		@(negedge dspif);
		window_cnt = 0;
		@(posedge dspif);
		nshot <= n;
		run_req <= 1'b1;
		wait_ack(1'b1, 60 * int'(n) + 50, ok);
		if (ok) begin
			check_value("shot windows", window_cnt, exp_windows(n));
			check_value("last_shot", last_shot, exp_last_shot(n));
			// ack must hold while the request stays up
			repeat (3) begin
				@(negedge dspif);
				check_value("run_ack", run_ack, 1);
			end
		end
		@(posedge dspif);
		run_req <= 1'b0;
		wait_ack(1'b0, 10, ok);
		check_value("proc_reset", proc_reset, 1);
	endtask

	// one sample per channel followed by an idle cycle
	task automatic drive_samples(input int count);
		acc_axis_t x;
		acc_axis_t y;
		for (int k = 0; k < count; k++) begin
			@(posedge dspif);
			for (int c = 0; c < N_CHAN; c++) begin
				data_rng = lcg(data_rng);
				x = acc_axis_t'(data_rng);
				data_rng = lcg(data_rng);
				y = acc_axis_t'(data_rng);
				acc_in[c] <= '{valid: 1'b1, x: x, y: y};
				exp_wr_q[c].push_back('{we: 1'b1, addr: exp_addr[c], data: {x, y}});
				exp_meas_q[c].push_back(exp_state(x));
				exp_addr[c] = next_addr(exp_addr[c]);
			end
			@(posedge dspif);
			for (int c = 0; c < N_CHAN; c++)
				acc_in[c] <= '{valid: 1'b0, x: '0, y: '0};
		end
	endtask

	task automatic end_test(input string name);
		if (errors == test_base)
			$display("test %0d %s: ok", tests + 1, name);
		else
			$display("test %0d %s: %0d errors", tests + 1, name, errors - test_base);
		test_base = errors;
		tests++;
	endtask

	initial begin
		bit ok;
		rst_n <= 1'b0;
		run_req <= 1'b0;
		nshot <= '0;
		acc_reset <= 1'b0;
		proc_done <= '0;
		elem_idle <= '1;
		for (int c = 0; c < N_CHAN; c++) begin
			acc_in[c] <= '0;
			exp_addr[c] = '0;
		end
		for (int c = 0; c < N_CORE; c++) begin
			done_cnt[c] <= 0;
			idle_cnt[c] <= 0;
		end
		repeat (10) @(posedge dspif);
		rst_n <= 1'b1;
		@(negedge dspif);
		check_reset_state();
		end_test("reset state");

		run_shots(3);
		end_test("three shot run");

		// second run must not carry anything over from the first
		run_shots(1);
		run_shots(2);
		end_test("single shot and repeat run");

		drive_samples(20);
		wait_drain(50);
		end_test("sample writes and address lock");

		@(posedge dspif);
		acc_reset <= 1'b1;
		for (int c = 0; c < N_CHAN; c++)
			exp_addr[c] = '0;
		@(posedge dspif);
		acc_reset <= 1'b0;
		@(negedge dspif);
		for (int c = 0; c < N_CHAN; c++)
			check_value($sformatf("acc_wr[%0d].addr", c), acc_wr[c].addr, 0);
		drive_samples(3);
		wait_drain(50);
		end_test("address clear");

		// zero shots runs until reset
		@(negedge dspif);
		window_cnt = 0;
		@(posedge dspif);
		nshot <= '0;
		run_req <= 1'b1;
		ok = 1'b0;
		for (int n = 0; n < 400 && !ok; n++) begin
			@(negedge dspif);
			check_value("run_ack", run_ack, 0);
			ok = (window_cnt >= 6);
		end
		if (!ok) begin
			$display("timeout waiting for six shot windows");
			errors++;
		end
		@(posedge dspif);
		rst_n <= 1'b0;
		run_req <= 1'b0;
		repeat (2) @(negedge dspif);
		check_reset_state();
		@(posedge dspif);
		rst_n <= 1'b1;
		repeat (3) @(negedge dspif);
		check_reset_state();
		end_test("endless run ended by reset");

		errors += dsp_top_i.dsp_checker_i.fail_count;
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

`default_nettype wire
